//--- include/boot_rom_image.svh
/*
 * boot ROM image, sixteen 64-bit words
 */

localparam int unsigned BootImageWords = 16;

localparam logic [63:0] BootImage [BootImageWords] = '{
  64'h0202_8293_0000_0297,
  64'h0005_8593_f140_2573,
  64'h0002_8067_0182_b283,
  64'h0000_0000_0000_0000,
  64'h0000_0000_8000_0000,
  64'h1050_0073_0ff0_000f,
  64'hffdf_f06f_0000_0013,
  64'h0000_0000_0000_0000,
  64'hedfe_0dd0_0000_0000,
  64'h3800_0000_f504_0000,
  64'h2800_0000_a404_0000,
  64'h1100_0000_1000_0000,
  64'h0000_0000_0000_0000,
  64'h0000_0000_3c03_0000,
  64'h0000_0000_0000_0000,
  64'h0100_0000_0000_0000
};

//--- verilog/soc_pkg.sv
/*
 * bus widths, address map, region and CLINT register enums,
 * boot ROM and fan controller sizes
 */
`default_nettype none

package soc_pkg;

  // --------------------
  // bus widths
  // --------------------
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 64;
  // byte offset inside a region, wide enough for the CLINT window
  localparam int unsigned OffsetWidth = 16;

  // --------------------
  // sizes
  // --------------------
  localparam int unsigned RomWords = 16;
  localparam int unsigned FanBits  = 4;

  // --------------------
  // address map
  // --------------------
  localparam logic [AddrWidth-1:0] RomBase     = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] RomLength   = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] ClintBase   = 32'h0200_0000;
  localparam logic [AddrWidth-1:0] ClintLength = 32'h0000_C000;
  localparam logic [AddrWidth-1:0] FanBase     = 32'h0300_0000;
  localparam logic [AddrWidth-1:0] FanLength   = 32'h0000_1000;

  // decoded bus target
  typedef enum logic [1:0] {
    REG_ROM,
    REG_CLINT,
    REG_FAN,
    REG_NONE
  } region_e;

  // CLINT register offsets, single hart
  typedef enum logic [OffsetWidth-1:0] {
    CLINT_MSIP     = 16'h0000,
    CLINT_MTIMECMP = 16'h4000,
    CLINT_MTIME    = 16'hBFF8
  } clint_reg_e;

endpackage

`default_nettype wire

//--- verilog/periph_xbar.sv
/*
 * address decoder for the strobe bus: picks a region,
 * drives one select per target and muxes the read data back
 */
`timescale 1ns/1ps
`default_nettype none

module periph_xbar import soc_pkg::*; (
  input  logic                   clk,
  input  logic                   ndmreset_n,
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [AddrWidth-1:0]   addr_i,
  input  logic [DataWidth-1:0]   wdata_i,
  input  logic [DataWidth-1:0]   rom_rdata_i,
  input  logic [DataWidth-1:0]   clint_rdata_i,
  input  logic [DataWidth-1:0]   fan_rdata_i,
  output logic                   rom_sel_o,
  output logic                   clint_sel_o,
  output logic                   fan_sel_o,
  output logic                   we_o,
  output logic [OffsetWidth-1:0] offset_o,
  output logic [DataWidth-1:0]   wdata_o,
  output logic                   rvalid_o,
  output logic [DataWidth-1:0]   rdata_o,
  output logic                   err_o
);

  region_e              region;
  region_e              region_q;
  logic [AddrWidth-1:0] base;
  logic [AddrWidth-1:0] rel_addr;
  logic                 legal;
  logic                 rvalid_q;
  logic                 err_q;
  logic                 wr_q;

  // --------------------
  // decode
  // --------------------
  always_comb begin
    region = REG_NONE;
    base   = '0;
    if (addr_i >= RomBase && addr_i < RomBase + RomLength) begin
      region = REG_ROM;
      base   = RomBase;
    end else if (addr_i >= ClintBase && addr_i < ClintBase + ClintLength) begin
      region = REG_CLINT;
      base   = ClintBase;
    end else if (addr_i >= FanBase && addr_i < FanBase + FanLength) begin
      region = REG_FAN;
      base   = FanBase;
    end
  end

  // the ROM cannot be written
  assign legal    = (region != REG_NONE) && !(region == REG_ROM && we_i);
  assign rel_addr = addr_i - base;

  assign rom_sel_o   = req_i && legal && (region == REG_ROM);
  assign clint_sel_o = req_i && legal && (region == REG_CLINT);
  assign fan_sel_o   = req_i && legal && (region == REG_FAN);

  assign we_o     = we_i;
  assign offset_o = {rel_addr[OffsetWidth-1:3], 3'b000};
  assign wdata_o  = wdata_i;

  // --------------------
  // response
  // --------------------
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      wr_q     <= 1'b0;
      region_q <= REG_NONE;
    end else begin
      rvalid_q <= req_i;
      err_q    <= req_i && !legal;
      wr_q     <= we_i;
      region_q <= region;
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;

  // targets registered their data on the same edge as region_q
  always_comb begin
    rdata_o = '0;
    if (rvalid_q && !err_q && !wr_q) begin
      case (region_q)
        REG_ROM:   rdata_o = rom_rdata_i;
        REG_CLINT: rdata_o = clint_rdata_i;
        REG_FAN:   rdata_o = fan_rdata_i;
        default:   rdata_o = '0;
      endcase
    end
  end

  a_one_select: assert property (@(posedge clk) disable iff (!ndmreset_n)
    $onehot0({rom_sel_o, clint_sel_o, fan_sel_o}));

  a_rvalid_latency: assert property (@(posedge clk) disable iff (!ndmreset_n)
    rvalid_o == $past(req_i));

endmodule

`default_nettype wire

//--- verilog/boot_rom.sv
/*
 * boot ROM with a registered read, word index wraps at RomWords
 */
`timescale 1ns/1ps
`default_nettype none

module boot_rom import soc_pkg::*; #(
  parameter int unsigned RomWords = soc_pkg::RomWords
) (
  input  logic                   clk,
  input  logic                   sel_i,
  input  logic [OffsetWidth-1:0] offset_i,
  output logic [DataWidth-1:0]   rdata_o
);

  `include "boot_rom_image.svh"

  localparam int unsigned IdxWidth = (RomWords > 1) ? $clog2(RomWords) : 1;

  logic [DataWidth-1:0] rom_table [RomWords];
  logic [IdxWidth-1:0]  word_idx;

  // image repeats if the ROM is larger than it
  for (genvar i = 0; i < RomWords; i++) begin : g_fill
    assign rom_table[i] = BootImage[i % BootImageWords];
  end

  // byte offset to word index
  assign word_idx = IdxWidth'(offset_i[OffsetWidth-1:3] % RomWords);

  always_ff @(posedge clk) begin
    if (sel_i) begin
      rdata_o <= rom_table[word_idx];
    end
  end

endmodule

`default_nettype wire

//--- verilog/clint_timer.sv
/*
 * core-local interruptor for one hart: rtc tick from clk / 2,
 * mtime, mtimecmp, msip and the timer and software interrupts
 */
`timescale 1ns/1ps
`default_nettype none

module clint_timer import soc_pkg::*; (
  input  logic                   clk,
  input  logic                   ndmreset_n,
  input  logic                   sel_i,
  input  logic                   we_i,
  input  logic [OffsetWidth-1:0] offset_i,
  input  logic [DataWidth-1:0]   wdata_i,
  output logic [DataWidth-1:0]   rdata_o,
  output logic                   timer_irq_o,
  output logic                   ipi_o
);

  logic                 rtc;
  logic                 rtc_q;
  logic                 rtc_rise;
  logic [DataWidth-1:0] mtime;
  logic [DataWidth-1:0] mtimecmp;
  logic                 msip;
  logic                 irq_q;

  // --------------------
  // real-time tick
  // --------------------
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc   <= 1'b0;
      rtc_q <= 1'b0;
    end else begin
      rtc   <= ~rtc;
      rtc_q <= rtc;
    end
  end

  assign rtc_rise = rtc && !rtc_q;

  // --------------------
  // registers
  // --------------------
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime    <= '0;
      mtimecmp <= '1;
      msip     <= 1'b0;
      irq_q    <= 1'b0;
    end else begin
      if (rtc_rise) begin
        mtime <= mtime + 1'b1;
      end
      // a bus write to mtime wins over the tick
      if (sel_i && we_i) begin
        case (offset_i)
          CLINT_MSIP:     msip     <= wdata_i[0];
          CLINT_MTIMECMP: mtimecmp <= wdata_i;
          CLINT_MTIME:    mtime    <= wdata_i;
          default:        ;
        endcase
      end
      irq_q <= (mtime >= mtimecmp);
    end
  end

  // read data, unknown offsets give zero
  always_ff @(posedge clk) begin
    if (sel_i) begin
      case (offset_i)
        CLINT_MSIP:     rdata_o <= {{(DataWidth-1){1'b0}}, msip};
        CLINT_MTIMECMP: rdata_o <= mtimecmp;
        CLINT_MTIME:    rdata_o <= mtime;
        default:        rdata_o <= '0;
      endcase
    end
  end

  assign timer_irq_o = irq_q;
  assign ipi_o       = msip;

  a_irq_matches_cmp: assert property (@(posedge clk) disable iff (!ndmreset_n)
    timer_irq_o == $past(mtime >= mtimecmp));

  // mtime only counts up, so only a bus write can drop a pending timer irq
  a_irq_holds: assert property (@(posedge clk) disable iff (!ndmreset_n)
    timer_irq_o && !$past(sel_i && we_i) |=> timer_irq_o);

endmodule

`default_nettype wire

//--- verilog/fan_pwm.sv
/*
 * fan controller: bus-writable duty setting and PWM output
 */
`timescale 1ns/1ps
`default_nettype none

module fan_pwm import soc_pkg::*; #(
  parameter int unsigned FanBits = soc_pkg::FanBits
) (
  input  logic                 clk,
  input  logic                 ndmreset_n,
  input  logic                 sel_i,
  input  logic                 we_i,
  input  logic [DataWidth-1:0] wdata_i,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 fan_pwm_o
);

  logic [FanBits-1:0] setting;
  logic [FanBits-1:0] pwm_cnt;

  // --------------------
  // setting and counter
  // --------------------
  // full speed out of reset
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      setting <= '1;
      pwm_cnt <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
      if (sel_i && we_i) begin
        setting <= wdata_i[FanBits-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sel_i) begin
      rdata_o <= {{(DataWidth-FanBits){1'b0}}, setting};
    end
  end

  // high for setting out of 2**FanBits cycles
  assign fan_pwm_o = (pwm_cnt < setting);

endmodule

`default_nettype wire

//--- verilog/fpga_soc_top.sv
/*
 * SoC shell top level: bus decoder, boot ROM, CLINT and fan PWM
 */
`timescale 1ns/1ps
`default_nettype none

module fpga_soc_top import soc_pkg::*; #(
  parameter int unsigned RomWords = soc_pkg::RomWords,
  parameter int unsigned FanBits  = soc_pkg::FanBits
) (
  input  logic                 clk,
  input  logic                 ndmreset_n,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0] wdata_i,
  output logic                 rvalid_o,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 err_o,
  output logic                 timer_irq_o,
  output logic                 ipi_o,
  output logic                 fan_pwm_o
);

  logic                   rom_sel;
  logic                   clint_sel;
  logic                   fan_sel;
  logic                   bus_we;
  logic [OffsetWidth-1:0] bus_offset;
  logic [DataWidth-1:0]   bus_wdata;
  logic [DataWidth-1:0]   rom_rdata;
  logic [DataWidth-1:0]   clint_rdata;
  logic [DataWidth-1:0]   fan_rdata;

  // --------------------
  // bus decoder
  // --------------------
  periph_xbar i_periph_xbar (
    .clk           ( clk         ),
    .ndmreset_n    ( ndmreset_n  ),
    .req_i         ( req_i       ),
    .we_i          ( we_i        ),
    .addr_i        ( addr_i      ),
    .wdata_i       ( wdata_i     ),
    .rom_rdata_i   ( rom_rdata   ),
    .clint_rdata_i ( clint_rdata ),
    .fan_rdata_i   ( fan_rdata   ),
    .rom_sel_o     ( rom_sel     ),
    .clint_sel_o   ( clint_sel   ),
    .fan_sel_o     ( fan_sel     ),
    .we_o          ( bus_we      ),
    .offset_o      ( bus_offset  ),
    .wdata_o       ( bus_wdata   ),
    .rvalid_o      ( rvalid_o    ),
    .rdata_o       ( rdata_o     ),
    .err_o         ( err_o       )
  );

  // --------------------
  // targets
  // --------------------
  boot_rom #(
    .RomWords ( RomWords )
  ) i_boot_rom (
    .clk      ( clk        ),
    .sel_i    ( rom_sel    ),
    .offset_i ( bus_offset ),
    .rdata_o  ( rom_rdata  )
  );

  clint_timer i_clint_timer (
    .clk         ( clk         ),
    .ndmreset_n  ( ndmreset_n  ),
    .sel_i       ( clint_sel   ),
    .we_i        ( bus_we      ),
    .offset_i    ( bus_offset  ),
    .wdata_i     ( bus_wdata   ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  fan_pwm #(
    .FanBits ( FanBits )
  ) i_fan_pwm (
    .clk        ( clk        ),
    .ndmreset_n ( ndmreset_n ),
    .sel_i      ( fan_sel    ),
    .we_i       ( bus_we     ),
    .wdata_i    ( bus_wdata  ),
    .rdata_o    ( fan_rdata  ),
    .fan_pwm_o  ( fan_pwm_o  )
  );

endmodule

`default_nettype wire

//--- dv/tb_fpga_soc_top.sv
/*
 * testbench for the SoC shell: clock, reset, random bus traffic,
 * reference model of ROM, CLINT and fan state, response checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_fpga_soc_top import soc_pkg::*; ();

  `include "boot_rom_image.svh"

  localparam logic [AddrWidth-1:0] MsipAddr  = ClintBase + AddrWidth'(CLINT_MSIP);
  localparam logic [AddrWidth-1:0] CmpAddr   = ClintBase + AddrWidth'(CLINT_MTIMECMP);
  localparam logic [AddrWidth-1:0] MtimeAddr = ClintBase + AddrWidth'(CLINT_MTIME);

  logic                 clk;
  logic                 ndmreset_n;
  logic                 req;
  logic                 we;
  logic [AddrWidth-1:0] addr;
  logic [DataWidth-1:0] wdata;
  logic                 rvalid;
  logic [DataWidth-1:0] rdata;
  logic                 err;
  logic                 timer_irq;
  logic                 ipi;
  logic                 fan_pwm;

  // model state
  logic                 msip_m;
  logic [DataWidth-1:0] cmp_m;
  logic [FanBits-1:0]   fan_m;

  logic [31:0] lcg_state;
  int unsigned checks;
  int unsigned value_errs;
  int unsigned timeout_errs;

  fpga_soc_top #(
    .RomWords ( RomWords ),
    .FanBits  ( FanBits  )
  ) UUT (
    .clk         ( clk        ),
    .ndmreset_n  ( ndmreset_n ),
    .req_i       ( req        ),
    .we_i        ( we         ),
    .addr_i      ( addr       ),
    .wdata_i     ( wdata      ),
    .rvalid_o    ( rvalid     ),
    .rdata_o     ( rdata      ),
    .err_o       ( err        ),
    .timer_irq_o ( timer_irq  ),
    .ipi_o       ( ipi        ),
    .fan_pwm_o   ( fan_pwm    )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------
  // random numbers and model helpers
  // --------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper bits only since the low LCG bits repeat quickly
  function automatic int unsigned rand_below(input int unsigned n);
    logic [31:0] r;
    r = lcg_next();
    return {16'h0, r[31:16]} % n;
  endfunction

  function automatic region_e region_of(input logic [AddrWidth-1:0] a);
    if (a >= RomBase && a < RomBase + RomLength) return REG_ROM;
    if (a >= ClintBase && a < ClintBase + ClintLength) return REG_CLINT;
    if (a >= FanBase && a < FanBase + FanLength) return REG_FAN;
    return REG_NONE;
  endfunction

  function automatic logic [DataWidth-1:0] rom_word(input logic [AddrWidth-1:0] a);
    int unsigned idx;
    idx = ((a - RomBase) >> 3) % RomWords;
    return BootImage[idx % BootImageWords];
  endfunction

  // edges of the map plus fully random addresses
  function automatic logic [AddrWidth-1:0] pick_unmapped();
    logic [AddrWidth-1:0] a;
    case (rand_below(4))
      0:       a = RomBase - 32'd8;
      1:       a = ClintBase + ClintLength;
      2:       a = FanBase + FanLength;
      default: a = lcg_next();
    endcase
    if (region_of(a) != REG_NONE) a = 32'hFFFF_FFF0;
    return a;
  endfunction

  // --------------------
  // compare tasks
  // --------------------
  task automatic compare_rdata(input logic [DataWidth-1:0] got,
                               input logic [DataWidth-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic verify_err(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0t: %s err_o is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic region_check(input region_e got, input region_e exp, input string what);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0t: %s decoded region %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic level_check(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic range_check(input longint unsigned got, input longint unsigned lo,
                             input longint unsigned hi, input string what);
    checks++;
    if (got < lo || got > hi) begin
      value_errs++;
      $display("ERR %0t: %s is %0d, expected %0d to %0d", $time, what, got, lo, hi);
    end
  endtask

  // --------------------
  // bus access
  // --------------------
  // called on a falling edge and returns on the next one
  task automatic access(input logic wr, input logic [AddrWidth-1:0] a,
                        input logic [DataWidth-1:0] wd, output logic [DataWidth-1:0] got);
    region_e                exp_region;
    logic                   exp_err;
    logic [DataWidth-1:0]   exp_data;
    logic                   data_known;
    logic [OffsetWidth-1:0] off;
    exp_region = region_of(a);
    exp_err    = (exp_region == REG_NONE) || (exp_region == REG_ROM && wr);
    exp_data   = '0;
    data_known = 1'b1;
    off        = OffsetWidth'((a - ClintBase) & ~32'h7);
    if (!exp_err && wr) begin
      if (exp_region == REG_FAN) fan_m = wd[FanBits-1:0];
      if (exp_region == REG_CLINT && off == CLINT_MSIP) msip_m = wd[0];
      if (exp_region == REG_CLINT && off == CLINT_MTIMECMP) cmp_m = wd;
    end else if (!exp_err) begin
      case (exp_region)
        REG_ROM: exp_data = rom_word(a);
        REG_FAN: exp_data = DataWidth'(fan_m);
        default: begin
          if (off == CLINT_MSIP) exp_data = DataWidth'(msip_m);
          else if (off == CLINT_MTIMECMP) exp_data = cmp_m;
          else if (off == CLINT_MTIME) data_known = 1'b0;
        end
      endcase
    end
    req   = 1'b1;
    we    = wr;
    addr  = a;
    wdata = wd;
    @(negedge clk);
    req = 1'b0;
    got = rdata;
    level_check(rvalid, 1'b1, "rvalid_o");
    verify_err(err, exp_err, "bus response");
    region_check(region_e'(UUT.i_periph_xbar.region_q), exp_region, "decoder");
    if (data_known) compare_rdata(rdata, exp_data, "bus response");
    level_check(ipi, msip_m, "ipi_o");
  endtask

  task automatic idle_cycle();
    req = 1'b0;
    we  = 1'b0;
    @(negedge clk);
    level_check(rvalid, 1'b0, "rvalid_o when idle");
    verify_err(err, 1'b0, "idle cycle");
    level_check(ipi, msip_m, "ipi_o");
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    logic [DataWidth-1:0] got;
    logic [DataWidth-1:0] got2;
    logic [AddrWidth-1:0] a;
    int unsigned          i;
    int unsigned          trial;
    int unsigned          n;
    int unsigned          k;
    int unsigned          hits;
    int unsigned          cnt;
    int unsigned          limit;
    lcg_state    = 32'd10732;
    checks       = 0;
    value_errs   = 0;
    timeout_errs = 0;
    msip_m       = 1'b0;
    cmp_m        = '1;
    fan_m        = '1;
    ndmreset_n   = 1'b0;
    req          = 1'b0;
    we           = 1'b0;
    addr         = '0;
    wdata        = '0;
    repeat (4) @(negedge clk);
    ndmreset_n = 1'b1;

    // state out of reset
    level_check(rvalid, 1'b0, "rvalid_o after reset");
    verify_err(err, 1'b0, "after reset");
    level_check(timer_irq, 1'b0, "timer_irq_o after reset");
    level_check(ipi, 1'b0, "ipi_o after reset");
    // first edge after reset, no tick has happened yet
    access(1'b0, MtimeAddr, '0, got);
    compare_rdata(got, '0, "mtime after reset");
    access(1'b0, CmpAddr, '0, got);
    access(1'b0, FanBase, '0, got);
    hits = 0;
    for (i = 0; i < 16; i++) begin
      @(negedge clk);
      if (fan_pwm) hits++;
    end
    range_check(hits, 15, 15, "fan_pwm_o high cycles at reset duty");

    // back-to-back ROM reads
    for (i = 0; i < 40; i++) begin
      access(1'b0, RomBase + rand_below(RomLength), '0, got);
    end
    idle_cycle();

    // erroring requests followed by reads that show nothing moved
    for (i = 0; i < 10; i++) begin
      a = RomBase + rand_below(RomLength);
      access(1'b1, a, {lcg_next(), lcg_next()}, got);
      access(1'b0, a, '0, got);
      access(rand_below(2) == 1, pick_unmapped(), {lcg_next(), lcg_next()}, got);
      access(1'b0, FanBase, '0, got);
      access(1'b0, MsipAddr, '0, got);
    end

    // random mix over all regions
    for (i = 0; i < 300; i++) begin
      case (rand_below(10))
        0, 1: access(1'b0, RomBase + rand_below(RomLength), '0, got);
        2:    access(1'b1, RomBase + rand_below(RomLength), {lcg_next(), lcg_next()}, got);
        3:    access(rand_below(2) == 1, pick_unmapped(), {lcg_next(), lcg_next()}, got);
        4:    access(1'b1, FanBase + rand_below(FanLength), {lcg_next(), lcg_next()}, got);
        5:    access(1'b0, FanBase + rand_below(FanLength), '0, got);
        6:    access(1'b1, MsipAddr, {lcg_next(), lcg_next()}, got);
        7:    access(1'b0, MsipAddr, '0, got);
        8:    access(rand_below(2) == 1, CmpAddr, {lcg_next(), lcg_next()}, got);
        default: begin
          // CLINT holes below mtimecmp
          a = ClintBase + 8 * (1 + rand_below(2000));
          access(rand_below(2) == 1, a, {lcg_next(), lcg_next()}, got);
        end
      endcase
      if (rand_below(4) == 0) idle_cycle();
    end
    idle_cycle();

    // software interrupt
    access(1'b1, MsipAddr, 64'h1, got);
    idle_cycle();
    level_check(ipi, 1'b1, "ipi_o after msip set");
    access(1'b1, MsipAddr, 64'h2, got);
    idle_cycle();
    level_check(ipi, 1'b0, "ipi_o after msip clear");

    // mtime advances one tick per two clocks
    for (trial = 0; trial < 3; trial++) begin
      n = 8 + rand_below(32);
      access(1'b0, MtimeAddr, '0, got);
      repeat (n - 1) idle_cycle();
      access(1'b0, MtimeAddr, '0, got2);
      range_check(got2 - got, n / 2 - 1, n / 2 + 1, "mtime advance");
    end

    // timer compare
    access(1'b1, CmpAddr, '1, got);
    idle_cycle();
    for (trial = 0; trial < 3; trial++) begin
      k = 5 + rand_below(16);
      access(1'b0, MtimeAddr, '0, got);
      access(1'b1, CmpAddr, got + k, got2);
      level_check(timer_irq, 1'b0, "timer_irq_o before compare");
      limit = 2 * k + 4;
      cnt   = 0;
      while (!timer_irq && cnt < limit) begin
        access(1'b0, MtimeAddr, '0, got2);
        level_check(timer_irq, got2 >= cmp_m, "timer_irq_o against mtime");
        cnt++;
      end
      if (!timer_irq) begin
        timeout_errs++;
        $display("timeout: timer_irq_o stayed low for %0d cycles after mtimecmp write",
                 limit);
      end
      access(1'b1, CmpAddr, '1, got);
      idle_cycle();
      level_check(timer_irq, 1'b0, "timer_irq_o after mtimecmp reset");
    end

    // fan duty
    for (trial = 0; trial < 4; trial++) begin
      access(1'b1, FanBase, {lcg_next(), lcg_next()}, got);
      access(1'b0, FanBase, '0, got);
      idle_cycle();
      hits = 0;
      for (i = 0; i < 16; i++) begin
        @(negedge clk);
        if (fan_pwm) hits++;
      end
      range_check(hits, fan_m, fan_m, "fan_pwm_o high cycles");
    end

    $display("checks %0d, value errors %0d, timeouts %0d", checks, value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- fpga_soc_top.f
+incdir+include
verilog/soc_pkg.sv
verilog/periph_xbar.sv
verilog/boot_rom.sv
verilog/clint_timer.sv
verilog/fan_pwm.sv
verilog/fpga_soc_top.sv
dv/tb_fpga_soc_top.sv

//--- Bender.yml
package:
  name: fpga_soc_top

export_include_dirs:
  - include

sources:
  - files:
      - verilog/soc_pkg.sv
      - verilog/periph_xbar.sv
      - verilog/boot_rom.sv
      - verilog/clint_timer.sv
      - verilog/fan_pwm.sv
      - verilog/fpga_soc_top.sv
  - target: test
    files:
      - dv/tb_fpga_soc_top.sv
